// ==== hart_shell.f ====
hdl/hart_shell_pkg.sv
hdl/core_clock_ctrl.sv
hdl/register_file_ff.sv
hdl/scramble_key_ctrl.sv
hdl/dside_tracker.sv
hdl/hart_shell.sv
+incdir+bench
bench/hart_shell_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the hart shell testbench with Verilator and run it.
# The simulator exits non-zero when the testbench stops on an error.
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module hart_shell_tb -f hart_shell.f -o hart_shell_sim

./obj_dir/hart_shell_sim

// ==== bench/hart_shell_tb_tasks.svh ====
//////////////////////////////////////////////////
// Hart shell testbench tasks
// Compare tasks and directed tests
//////////////////////////////////////////////////

`ifndef HART_SHELL_TB_TASKS_SVH
`define HART_SHELL_TB_TASKS_SVH

task automatic stop_on_error();
  $display("Result: FAILED");
  $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_data(input string test, input reg_data_t exp, input reg_data_t act);
  if (act !== exp) begin
    $display("Fail %s: expected %h, actual %h", test, exp, act);
    stop_on_error();
  end
endtask

task automatic check_bit(input string test, input logic exp, input logic act);
  if (act !== exp) begin
    $display("Fail %s: expected %b, actual %b", test, exp, act);
    stop_on_error();
  end
endtask

task automatic check_alert(input string test, input alert_t exp, input alert_t act);
  if (act !== exp) begin
    $display("Fail %s: expected %b, actual %b", test, exp, act);
    stop_on_error();
  end
endtask

task automatic check_key(input string test, input scr_key_t exp, input scr_key_t act);
  if (act !== exp) begin
    $display("Fail %s: expected %h, actual %h", test, exp, act);
    stop_on_error();
  end
endtask

task automatic check_nonce(input string test, input scr_nonce_t exp, input scr_nonce_t act);
  if (act !== exp) begin
    $display("Fail %s: expected %h, actual %h", test, exp, act);
    stop_on_error();
  end
endtask

//////////////////////////////////////////////////
// Stimulus helpers
//////////////////////////////////////////////////

// Inputs change on the falling edge, checks run a quarter period later
task automatic next_cycle();
  @(negedge clk_i);
endtask

task automatic settle();
  #(ClkPeriod / 4);
endtask

task automatic init_inputs();
  rst_ni               = 1'b0;
  test_en_i            = 1'b0;
  core_busy_i          = 1'b0;
  debug_req_i          = 1'b0;
  irq_pending_i        = 1'b0;
  irq_nm_i             = 1'b0;
  dummy_instr_id_i     = 1'b0;
  rf_raddr_a_i         = '0;
  rf_raddr_b_i         = '0;
  rf_wr_i              = '0;
  ic_scr_key_req_i     = 1'b0;
  scramble_key_valid_i = 1'b0;
  scramble_key_i       = '0;
  scramble_nonce_i     = '0;
  data_req_i           = '0;
  data_gnt_i           = 1'b0;
  data_rvalid_i        = 1'b0;
  core_alert_i         = '0;
endtask

task automatic drive_data(input logic req, input logic we, input logic gnt,
                          input logic rvalid);
  data_req_i.req  = req;
  data_req_i.we   = we;
  data_req_i.be   = 4'hf;
  data_req_i.addr = 32'h0000_2000;
  data_gnt_i      = gnt;
  data_rvalid_i   = rvalid;
endtask

task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
  rf_wr_i.we    = 1'b1;
  rf_wr_i.waddr = addr;
  rf_wr_i.wdata = data;
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic test_scramble_reset();
  settle();
  check_bit("scramble reset valid", 1'b1, ic_scr_key_valid_o);
  check_bit("scramble reset request", 1'b0, scramble_req_o);
  check_key("scramble reset key", KeyDefault, ic_scr_key_o);
  check_nonce("scramble reset nonce", NonceDefault, ic_scr_nonce_o);
  next_cycle();
endtask

task automatic test_scramble_handshake();
  scr_key_t   new_key;
  scr_nonce_t new_nonce;
  new_key          = rand_key();
  new_nonce        = rand_nonce();
  ic_scr_key_req_i = 1'b1;
  next_cycle();
  ic_scr_key_req_i = 1'b0;
  settle();
  check_bit("key request sets request", 1'b1, scramble_req_o);
  check_bit("key request clears valid", 1'b0, ic_scr_key_valid_o);
  next_cycle();
  // Request holds while the key source is quiet
  settle();
  check_bit("request held", 1'b1, scramble_req_o);
  next_cycle();
  scramble_key_valid_i = 1'b1;
  scramble_key_i       = new_key;
  scramble_nonce_i     = new_nonce;
  next_cycle();
  scramble_key_valid_i = 1'b0;
  settle();
  check_bit("key arrival clears request", 1'b0, scramble_req_o);
  check_bit("key arrival sets valid", 1'b1, ic_scr_key_valid_o);
  check_key("new key", new_key, ic_scr_key_o);
  check_nonce("new nonce", new_nonce, ic_scr_nonce_o);
  next_cycle();
endtask

task automatic test_register_file();
  reg_addr_t idx;
  reg_addr_t idx_b;
  core_busy_i = 1'b1;
  next_cycle();
  rf_model[0] = '0;
  for (int i = 1; i < 32; i++) begin
    idx           = reg_addr_t'(i);
    rf_model[idx] = rand_word();
    write_reg(idx, rf_model[idx]);
    next_cycle();
  end
  rf_wr_i.we = 1'b0;
  for (int i = 0; i < 32; i++) begin
    idx          = reg_addr_t'(i);
    idx_b        = ~idx;
    rf_raddr_a_i = idx;
    rf_raddr_b_i = idx_b;
    settle();
    check_data("register read port a", rf_model[idx], rf_rdata_a_o);
    check_data("register read port b", rf_model[idx_b], rf_rdata_b_o);
    next_cycle();
  end
endtask

task automatic test_dummy_x0();
  reg_data_t word;
  word             = rand_word();
  dummy_instr_id_i = 1'b1;
  write_reg('0, word);
  next_cycle();
  rf_wr_i.we   = 1'b0;
  rf_raddr_a_i = '0;
  rf_raddr_b_i = '0;
  settle();
  check_data("dummy x0 port a", word, rf_rdata_a_o);
  check_data("dummy x0 port b", word, rf_rdata_b_o);
  next_cycle();
  dummy_instr_id_i = 1'b0;
  rf_raddr_b_i     = 5'd1;
  settle();
  check_data("real x0 reads zero", rf_model[0], rf_rdata_a_o);
  check_data("x1 untouched by dummy write", rf_model[1], rf_rdata_b_o);
  next_cycle();
endtask

task automatic test_sleep();
  core_busy_i = 1'b0;
  settle();
  check_bit("awake while busy is registered", 1'b0, core_sleep_o);
  next_cycle();
  // Gate is closed for this edge
  write_reg(5'd5, ~rf_model[5]);
  settle();
  check_bit("asleep after busy falls", 1'b1, core_sleep_o);
  next_cycle();
  rf_wr_i.we   = 1'b0;
  rf_raddr_a_i = 5'd5;
  settle();
  check_data("write while asleep", rf_model[5], rf_rdata_a_o);
  next_cycle();
  irq_nm_i = 1'b1;
  settle();
  check_bit("nmi wakes at once", 1'b0, core_sleep_o);
  next_cycle();
  core_busy_i = 1'b1;
  next_cycle();
  irq_nm_i = 1'b0;
  settle();
  check_bit("awake with busy again", 1'b0, core_sleep_o);
  next_cycle();
endtask

task automatic test_dside_order();
  drive_data(1'b1, 1'b0, 1'b1, 1'b0);
  next_cycle();
  drive_data(1'b1, 1'b1, 1'b1, 1'b0);
  next_cycle();
  drive_data(1'b0, 1'b0, 1'b0, 1'b1);
  settle();
  check_bit("read response done", 1'b1, data_read_done_o);
  next_cycle();
  settle();
  check_bit("write response not done", 1'b0, data_read_done_o);
  check_alert("ordered responses", '0, alert_o);
  next_cycle();
  drive_data(1'b0, 1'b0, 1'b0, 1'b0);
  settle();
  check_alert("ordered accesses", '0, alert_o);
  next_cycle();
endtask

task automatic test_dside_no_pending();
  alert_t bus_alert;
  bus_alert           = '0;
  bus_alert.major_bus = 1'b1;
  drive_data(1'b0, 1'b0, 1'b0, 1'b1);
  settle();
  check_bit("stray response not done", 1'b0, data_read_done_o);
  check_alert("stray response same cycle", '0, alert_o);
  next_cycle();
  drive_data(1'b0, 1'b0, 1'b0, 1'b0);
  settle();
  check_alert("stray response next cycle", bus_alert, alert_o);
  next_cycle();
  settle();
  check_alert("stray response pulse end", '0, alert_o);
  next_cycle();
endtask

task automatic test_dside_overflow();
  alert_t bus_alert;
  bus_alert           = '0;
  bus_alert.major_bus = 1'b1;
  drive_data(1'b1, 1'b0, 1'b1, 1'b0);
  next_cycle();
  next_cycle();
  // Third request while both slots are taken
  drive_data(1'b1, 1'b0, 1'b0, 1'b0);
  settle();
  check_alert("overflow same cycle", '0, alert_o);
  next_cycle();
  drive_data(1'b0, 1'b0, 1'b0, 1'b1);
  settle();
  check_alert("overflow next cycle", bus_alert, alert_o);
  check_bit("first read done", 1'b1, data_read_done_o);
  next_cycle();
  settle();
  check_alert("overflow pulse end", '0, alert_o);
  check_bit("second read done", 1'b1, data_read_done_o);
  next_cycle();
  drive_data(1'b0, 1'b0, 1'b0, 1'b0);
  settle();
  check_alert("tracker drained", '0, alert_o);
  next_cycle();
endtask

task automatic test_alert_pass();
  alert_t pattern;
  for (int i = 0; i < 8; i++) begin
    pattern      = alert_t'(3'(i));
    core_alert_i = pattern;
    settle();
    check_alert("alert pass-through", pattern, alert_o);
    next_cycle();
  end
  core_alert_i = '0;
endtask

`endif

// ==== bench/hart_shell_tb.sv ====
//////////////////////////////////////////////////
// Hart shell testbench
// Clock, reset and directed tests of the shell blocks
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module hart_shell_tb import hart_shell_pkg::*; ();

  localparam int          ClkPeriod     = 8;
  // Tests take a few hundred cycles
  localparam int unsigned TimeoutCycles = 3000;

  logic       clk_i;
  logic       rst_ni;
  logic       test_en_i;
  logic       core_busy_i;
  logic       debug_req_i;
  logic       irq_pending_i;
  logic       irq_nm_i;
  logic       core_sleep_o;
  logic       dummy_instr_id_i;
  reg_addr_t  rf_raddr_a_i;
  reg_addr_t  rf_raddr_b_i;
  rf_wr_t     rf_wr_i;
  reg_data_t  rf_rdata_a_o;
  reg_data_t  rf_rdata_b_o;
  logic       ic_scr_key_req_i;
  logic       scramble_key_valid_i;
  scr_key_t   scramble_key_i;
  scr_nonce_t scramble_nonce_i;
  logic       scramble_req_o;
  logic       ic_scr_key_valid_o;
  scr_key_t   ic_scr_key_o;
  scr_nonce_t ic_scr_nonce_o;
  data_req_t  data_req_i;
  logic       data_gnt_i;
  logic       data_rvalid_i;
  logic       data_read_done_o;
  alert_t     core_alert_i;
  alert_t     alert_o;

  // Expected register contents as seen by real instructions
  reg_data_t   rf_model [32];
  logic [15:0] lfsr_q;
  int unsigned cycle_cnt = 0;

  hart_shell #(
    .RV32E            (1'b0),
    .DummyInstructions(1'b1)
  ) hart_shell_i (
    .clk_i, .rst_ni, .test_en_i, .core_busy_i, .debug_req_i, .irq_pending_i,
    .irq_nm_i, .core_sleep_o, .dummy_instr_id_i, .rf_raddr_a_i, .rf_raddr_b_i,
    .rf_wr_i, .rf_rdata_a_o, .rf_rdata_b_o, .ic_scr_key_req_i, .scramble_key_valid_i,
    .scramble_key_i, .scramble_nonce_i, .scramble_req_o, .ic_scr_key_valid_o,
    .ic_scr_key_o, .ic_scr_nonce_o, .data_req_i, .data_gnt_i, .data_rvalid_i,
    .data_read_done_o, .core_alert_i, .alert_o
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  //////////////////////////////////////////////////
  // Random data
  //////////////////////////////////////////////////

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11
  function automatic logic lfsr_next_bit();
    logic out_bit;
    logic fb;
    out_bit = lfsr_q[15];
    fb      = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q  = {lfsr_q[14:0], fb};
    return out_bit;
  endfunction

  function automatic reg_data_t rand_word();
    reg_data_t w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w = {w[30:0], lfsr_next_bit()};
    end
    return w;
  endfunction

  function automatic scr_key_t rand_key();
    scr_key_t k;
    k = '0;
    for (int n = 0; n < 4; n++) begin
      k = {k[95:0], rand_word()};
    end
    return k;
  endfunction

  function automatic scr_nonce_t rand_nonce();
    scr_nonce_t v;
    v = '0;
    for (int n = 0; n < 2; n++) begin
      v = {v[31:0], rand_word()};
    end
    return v;
  endfunction

  `include "hart_shell_tb_tasks.svh"

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
      stop_on_error();
    end
  end

  initial begin
    lfsr_q = 16'd50;
    init_inputs();
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    test_scramble_reset();
    test_scramble_handshake();
    test_register_file();
    test_dummy_x0();
    test_sleep();
    test_dside_order();
    test_dside_no_pending();
    test_dside_overflow();
    test_alert_pass();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/hart_shell.sv ====
//////////////////////////////////////////////////
// Hart shell
// Clock gating, register file, scramble key handshake and
// data side tracking around a RISC-V hart core
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module hart_shell import hart_shell_pkg::*; #(
  parameter bit         RV32E             = 1'b0,
  parameter bit         DummyInstructions = 1'b0,
  parameter scr_key_t   RndCnstKey        = KeyDefault,
  parameter scr_nonce_t RndCnstNonce      = NonceDefault
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Forces the clock gate open for test
  input  logic       test_en_i,

  // Core activity and wake-up sources
  input  logic       core_busy_i,
  input  logic       debug_req_i,
  input  logic       irq_pending_i,
  input  logic       irq_nm_i,
  output logic       core_sleep_o,

  // Register file
  input  logic       dummy_instr_id_i,
  input  reg_addr_t  rf_raddr_a_i,
  input  reg_addr_t  rf_raddr_b_i,
  input  rf_wr_t     rf_wr_i,
  output reg_data_t  rf_rdata_a_o,
  output reg_data_t  rf_rdata_b_o,

  // Instruction cache scrambling
  input  logic       ic_scr_key_req_i,
  input  logic       scramble_key_valid_i,
  input  scr_key_t   scramble_key_i,
  input  scr_nonce_t scramble_nonce_i,
  output logic       scramble_req_o,
  output logic       ic_scr_key_valid_o,
  output scr_key_t   ic_scr_key_o,
  output scr_nonce_t ic_scr_nonce_o,

  // Data side bus
  input  data_req_t  data_req_i,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  output logic       data_read_done_o,

  // Alerts
  input  alert_t     core_alert_i,
  output alert_t     alert_o
);

  logic clk_core;
  logic tracker_bus_err;

  //////////////////////////////////////////////////
  // Main clock gate
  //////////////////////////////////////////////////
  core_clock_ctrl core_clock_ctrl_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .clk_core_o   (clk_core),
    .core_sleep_o (core_sleep_o)
  );

  // Register file sits in the gated domain with the core
  register_file_ff #(
    .RV32E            (RV32E),
    .DummyInstructions(DummyInstructions)
  ) register_file_i (
    .clk_i           (clk_core),
    .rst_ni          (rst_ni),
    .dummy_instr_id_i(dummy_instr_id_i),
    .raddr_a_i       (rf_raddr_a_i),
    .raddr_b_i       (rf_raddr_b_i),
    .wr_i            (rf_wr_i),
    .rdata_a_o       (rf_rdata_a_o),
    .rdata_b_o       (rf_rdata_b_o)
  );

  //////////////////////////////////////////////////
  // Scrambling and bus tracking
  //////////////////////////////////////////////////
  scramble_key_ctrl #(
    .RndCnstKey  (RndCnstKey),
    .RndCnstNonce(RndCnstNonce)
  ) scramble_key_ctrl_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .key_req_i     (ic_scr_key_req_i),
    .key_valid_i   (scramble_key_valid_i),
    .key_i         (scramble_key_i),
    .nonce_i       (scramble_nonce_i),
    .scramble_req_o(scramble_req_o),
    .key_valid_o   (ic_scr_key_valid_o),
    .key_o         (ic_scr_key_o),
    .nonce_o       (ic_scr_nonce_o)
  );

  dside_tracker dside_tracker_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .data_req_i   (data_req_i),
    .data_gnt_i   (data_gnt_i),
    .data_rvalid_i(data_rvalid_i),
    .read_done_o  (data_read_done_o),
    .bus_err_o    (tracker_bus_err)
  );

  // Tracker errors count as bus alerts
  always_comb begin
    alert_o           = core_alert_i;
    alert_o.major_bus = core_alert_i.major_bus | tracker_bus_err;
  end

endmodule

`default_nettype wire

// ==== hdl/dside_tracker.sv ====
//////////////////////////////////////////////////
// Data side access tracker
// Follows outstanding accesses and flags bus protocol errors
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dside_tracker import hart_shell_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  data_req_t data_req_i,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  output logic      read_done_o,
  output logic      bus_err_o
);

  typedef struct packed {
    logic valid;
    logic is_read;
  } slot_t;

  slot_t slot_q     [MaxOutstanding];
  slot_t slot_shift [MaxOutstanding];
  slot_t slot_d     [MaxOutstanding];
  logic  accept;
  logic  slot_placed;
  logic  err_no_pending;
  logic  err_overflow;
  logic  bus_err_q;

  assign accept = data_req_i.req & data_gnt_i;

  //////////////////////////////////////////////////
  // Slot queue, oldest access in slot 0
  //////////////////////////////////////////////////

  // A response retires slot 0 and moves the rest down
  always_comb begin
    for (int i = 0; i < MaxOutstanding - 1; i++) begin
      slot_shift[i] = data_rvalid_i ? slot_q[i+1] : slot_q[i];
    end
    slot_shift[MaxOutstanding-1] = data_rvalid_i ? '0 : slot_q[MaxOutstanding-1];
  end

  // New access goes into the first free slot after the shift
  always_comb begin
    slot_d      = slot_shift;
    slot_placed = 1'b0;
    if (accept) begin
      for (int i = 0; i < MaxOutstanding; i++) begin
        if (!slot_placed && !slot_shift[i].valid) begin
          slot_d[i].valid   = 1'b1;
          slot_d[i].is_read = ~data_req_i.we;
          slot_placed       = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MaxOutstanding; i++) begin
        slot_q[i] <= '0;
      end
    end else begin
      slot_q <= slot_d;
    end
  end

  assign read_done_o = data_rvalid_i & slot_q[0].valid & slot_q[0].is_read;

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  // Response with nothing in flight
  assign err_no_pending = data_rvalid_i & ~slot_q[0].valid;
  // Request while full, unless a slot frees up this cycle
  assign err_overflow   = data_req_i.req & slot_q[MaxOutstanding-1].valid & ~data_rvalid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_err_q <= 1'b0;
    end else begin
      bus_err_q <= err_no_pending | err_overflow;
    end
  end

  assign bus_err_o = bus_err_q;

endmodule

`default_nettype wire

// ==== hdl/scramble_key_ctrl.sv ====
//////////////////////////////////////////////////
// Scramble key control
// Requests a fresh key and holds the current key and nonce
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module scramble_key_ctrl import hart_shell_pkg::*; #(
  parameter scr_key_t   RndCnstKey   = KeyDefault,
  parameter scr_nonce_t RndCnstNonce = NonceDefault
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       key_req_i,
  input  logic       key_valid_i,
  input  scr_key_t   key_i,
  input  scr_nonce_t nonce_i,
  output logic       scramble_req_o,
  output logic       key_valid_o,
  output scr_key_t   key_o,
  output scr_nonce_t nonce_o
);

  logic req_d, req_q;
  logic valid_d, valid_q;

  // Request rises on the cache's invalidate and holds until a key arrives
  assign req_d = req_q ? ~key_valid_i : key_req_i;

  // Key is invalid from the request until the key source answers
  assign valid_d = req_q     ? key_valid_i :
                   key_req_i ? 1'b0        :
                               valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q   <= 1'b0;
      valid_q <= 1'b1;
    end else begin
      req_q   <= req_d;
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_o   <= RndCnstKey;
      nonce_o <= RndCnstNonce;
    end else if (key_valid_i) begin
      key_o   <= key_i;
      nonce_o <= nonce_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = valid_q;

endmodule

`default_nettype wire

// ==== hdl/register_file_ff.sv ====
//////////////////////////////////////////////////
// Flip-flop register file
// Two read ports, one write port, optional x0 shadow
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module register_file_ff import hart_shell_pkg::*; #(
  parameter bit RV32E             = 1'b0,
  parameter bit DummyInstructions = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      dummy_instr_id_i,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  rf_wr_t    wr_i,
  output reg_data_t rdata_a_o,
  output reg_data_t rdata_b_o
);

  localparam int unsigned NumWords = RV32E ? 16 : 32;
  localparam int unsigned AddrW    = RV32E ? 4 : 5;

  logic [AddrW-1:0]    waddr;
  logic [NumWords-1:0] we_dec;
  reg_data_t           rf_q [1:NumWords-1];
  reg_data_t           rf_words [NumWords];
  reg_data_t           x0_rdata;

  // Upper index bit dropped for RV32E, so x16 aliases x0
  assign waddr = wr_i.waddr[AddrW-1:0];

  always_comb begin
    for (int i = 0; i < NumWords; i++) begin
      we_dec[i] = wr_i.we && (waddr == AddrW'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NumWords; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NumWords; i++) begin
        if (we_dec[i]) begin
          rf_q[i] <= wr_i.wdata;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // x0 shadow for dummy instructions
  //////////////////////////////////////////////////
  if (DummyInstructions) begin : gen_dummy
    reg_data_t shadow_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        shadow_q <= '0;
      end else if (we_dec[0] && dummy_instr_id_i) begin
        shadow_q <= wr_i.wdata;
      end
    end

    // Real instructions still see a hardwired zero
    assign x0_rdata = dummy_instr_id_i ? shadow_q : '0;
  end else begin : gen_no_dummy
    assign x0_rdata = '0;
  end

  always_comb begin
    rf_words[0] = x0_rdata;
    for (int i = 1; i < NumWords; i++) begin
      rf_words[i] = rf_q[i];
    end
  end

  assign rdata_a_o = rf_words[raddr_a_i[AddrW-1:0]];
  assign rdata_b_o = rf_words[raddr_b_i[AddrW-1:0]];

endmodule

`default_nettype wire

// ==== hdl/core_clock_ctrl.sv ====
//////////////////////////////////////////////////
// Core clock control
// Tracks core activity and gates the core clock while asleep
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_clock_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clk_core_o,
  output logic core_sleep_o
);

  logic busy_q;
  logic clock_en;
  logic en_latch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  // Any wake-up source restarts the clock at once
  assign clock_en     = busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  // Transparent while the clock is low, so the enable is stable during the high phase
  always_latch begin
    if (!clk_i) begin
      en_latch <= clock_en | test_en_i;
    end
  end

  assign clk_core_o = clk_i & en_latch;

endmodule

`default_nettype wire

// ==== hdl/hart_shell_pkg.sv ====
//////////////////////////////////////////////////
// Hart shell package
// Widths, bus structs and reset constants shared by the shell
//////////////////////////////////////////////////

`default_nettype none

package hart_shell_pkg;

  // Register file word and index
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // One write from the writeback stage
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    reg_data_t wdata;
  } rf_wr_t;

  // Instruction cache scrambling material
  typedef logic [127:0] scr_key_t;
  typedef logic [63:0]  scr_nonce_t;

  // Data side request as seen by the tracker
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
  } data_req_t;

  typedef struct packed {
    logic minor;
    logic major_internal;
    logic major_bus;
  } alert_t;

  // A misaligned load or store can split into two bus accesses
  localparam int unsigned MaxOutstanding = 2;

  localparam scr_key_t   KeyDefault   = 128'h1f3c_a8e5_77d2_0b94_c6e1_5a03_9d2f_84b7;
  localparam scr_nonce_t NonceDefault = 64'h6b2e_d415_f09a_3c87;

endpackage

`default_nettype wire
